// ==== source/cvt_defines.svh ====
`ifndef CVT_DEFINES_SVH
`define CVT_DEFINES_SVH

// apb bus widths
`define CVT_AW 4
`define CVT_DW 32

// register byte offsets
`define CVT_REG_CTRL    4'h0
`define CVT_REG_OPERAND 4'h4
`define CVT_REG_RESULT  4'h8
`define CVT_REG_STATUS  4'hC

`endif

// ==== source/fp_pkg.sv ====
package fp_pkg;

    // rounding modes, codes 5 to 7 behave as rne
    typedef enum logic [2:0] {
        rne = 3'd0, // nearest, ties to even
        rtz = 3'd1, // toward zero
        rdn = 3'd2, // toward -inf
        rup = 3'd3, // toward +inf
        rmm = 3'd4  // nearest, ties away from zero
    } round_mode_t;

    // exception flags in the usual fflags order
    typedef struct packed {
        logic nv; // invalid
        logic dz; // divide by zero
        logic of; // overflow
        logic uf; // underflow
        logic nx; // inexact
    } fp_flags_t;

    // single precision exponent bias
    localparam logic [7:0] exp_bias = 8'd127;

endpackage

// ==== source/csr_pkg.sv ====
package csr_pkg;

    // register index after address decode
    typedef enum logic [2:0] {
        reg_ctrl    = 3'd0,
        reg_operand = 3'd1,
        reg_result  = 3'd2,
        reg_status  = 3'd3,
        reg_none    = 3'd4  // unmapped, reads zero
    } reg_idx_t;

    // status word, busy in bit 0
    typedef struct packed {
        logic [24:0]       rsvd;
        fp_pkg::fp_flags_t flags;  // bits 6:2
        logic              done;   // bit 1
        logic              busy;   // bit 0
    } status_t;

endpackage

// ==== source/fp_round.sv ====
module fp_round (
    input  logic [23:0]         mant,
    input  logic signed [9:0]   exp,
    input  logic                guard,
    input  logic                round_bit,
    input  logic                sticky,
    input  fp_pkg::round_mode_t rm,
    output logic [23:0]         mant_out,
    output logic [9:0]          exp_out,
    output logic                inexact
);
    import fp_pkg::*;

    logic        inc;     // round up by one ulp
    logic [24:0] mant_inc;

    assign inexact  = guard | round_bit | sticky;
    assign mant_inc = {1'b0, mant} + 25'd1;

    // operand is never negative, so rdn acts like rtz and rup on any inexact value
    always_comb begin
        case (rm)
            rtz, rdn: inc = 1'b0;
            rup:      inc = inexact;
            rmm:      inc = guard;
            default:  inc = guard & (round_bit | sticky | mant[0]); // rne and spare codes
        endcase
    end

    always_comb begin
        if (inc && mant_inc[24]) begin
            // mantissa overflowed, renormalize
            mant_out = 24'h800000;
            exp_out  = exp + 10'sd1;
        end else if (inc) begin
            mant_out = mant_inc[23:0];
            exp_out  = exp;
        end else begin
            mant_out = mant;
            exp_out  = exp;
        end
    end

endmodule

// ==== source/uint_to_float.sv ====
module uint_to_float (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic [31:0]         operand,
    input  fp_pkg::round_mode_t rm,
    output logic                busy,
    output logic                valid,
    output logic [31:0]         result,
    output fp_pkg::fp_flags_t   flags
);
    import fp_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_shift,
        st_pack,
        st_put
    } state_t;

    state_t            state;
    logic [31:0]       value_q;   // operand being normalized
    round_mode_t       rm_q;
    logic signed [9:0] exp_q;
    logic [23:0]       mant_q;
    logic              guard_q;
    logic              round_q;
    logic              sticky_q;
    logic [23:0]       mant_rnd;
    logic [9:0]        exp_rnd;
    logic              nx;

    fp_round u_round (
        .mant      (mant_q),
        .exp       (exp_q),
        .guard     (guard_q),
        .round_bit (round_q),
        .sticky    (sticky_q),
        .rm        (rm_q),
        .mant_out  (mant_rnd),
        .exp_out   (exp_rnd),
        .inexact   (nx)
    );

    assign busy  = (state == st_load) || (state == st_shift) || (state == st_pack);
    assign valid = (state == st_put);

    // control
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (start) state <= st_load;
                st_load:  state <= (value_q == 32'd0) ? st_pack : st_shift;
                st_shift: if (value_q[31]) state <= st_pack;
                st_pack:  state <= st_put;
                default:  state <= st_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (start) begin
                    value_q <= operand;
                    rm_q    <= rm;
                end
            end
            st_load: begin
                mant_q   <= '0;
                guard_q  <= 1'b0;
                round_q  <= 1'b0;
                sticky_q <= 1'b0;
                exp_q    <= (value_q == 32'd0) ? -10'sd127 : 10'sd31; // -127 packs to +0
            end
            st_shift: begin
                if (!value_q[31]) begin
                    value_q <= value_q << 1;
                    exp_q   <= exp_q - 10'sd1;
                end else begin
                    mant_q   <= value_q[31:8];
                    guard_q  <= value_q[7];
                    round_q  <= value_q[6];
                    sticky_q <= |value_q[5:0];
                end
            end
            st_pack: begin
                result <= {1'b0, exp_rnd[7:0] + exp_bias, mant_rnd[22:0]};
                flags  <= '{nv: 1'b0, dz: 1'b0, of: 1'b0, uf: 1'b0, nx: nx};
            end
            default: ;
        endcase
    end

endmodule

// ==== source/cvt_apb_regs.sv ====
`include "cvt_defines.svh"

module cvt_apb_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`CVT_AW-1:0]  paddr,
    input  logic [`CVT_DW-1:0]  pwdata,
    output logic [`CVT_DW-1:0]  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                start,
    output logic [31:0]         operand,
    output fp_pkg::round_mode_t rm,
    input  logic                busy,
    input  logic                valid,
    input  logic [31:0]         result,
    input  fp_pkg::fp_flags_t   flags
);
    import fp_pkg::*;
    import csr_pkg::*;

    reg_idx_t  idx;
    logic      wr;
    logic      wr_err;
    logic      op_ok;    // accepted operand write
    logic [31:0] result_q;
    fp_flags_t flags_q;
    logic      done_q;
    status_t   status;

    function automatic reg_idx_t decode(input logic [`CVT_AW-1:0] addr);
        case (addr)
            `CVT_REG_CTRL:    return reg_ctrl;
            `CVT_REG_OPERAND: return reg_operand;
            `CVT_REG_RESULT:  return reg_result;
            `CVT_REG_STATUS:  return reg_status;
            default:          return reg_none;
        endcase
    endfunction

    assign idx    = decode(paddr);
    assign wr     = psel & penable & pwrite;
    // busy alone misses the cycle where start is still in flight
    assign wr_err = wr & ((idx == reg_result) || (idx == reg_status) ||
                          ((idx == reg_operand) && (busy || start)));
    assign op_ok  = wr & (idx == reg_operand) & ~wr_err;

    assign pready  = 1'b1;  // no wait states
    assign pslverr = wr_err;

    assign status = '{rsvd: '0, flags: flags_q, done: done_q, busy: busy};

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (idx)
                reg_ctrl:    prdata = {{(`CVT_DW-3){1'b0}}, rm};
                reg_operand: prdata = operand;
                reg_result:  prdata = result_q;
                reg_status:  prdata = status;
                default:     prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rm       <= rne;
            operand  <= '0;
            result_q <= '0;
            flags_q  <= '0;
            done_q   <= 1'b0;
            start    <= 1'b0;
        end else begin
            start <= op_ok; // pulse one cycle after the access phase
            if (wr && idx == reg_ctrl) rm <= round_mode_t'(pwdata[2:0]);
            if (op_ok) operand <= pwdata;
            if (valid) begin
                result_q <= result;
                flags_q  <= flags;
                done_q   <= 1'b1;
            end else if (start) begin
                done_q <= 1'b0;
            end
        end
    end

endmodule

// ==== source/cvt_top.sv ====
`include "cvt_defines.svh"

module cvt_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`CVT_AW-1:0] paddr,
    input  logic [`CVT_DW-1:0] pwdata,
    output logic [`CVT_DW-1:0] prdata,
    output logic               pready,
    output logic               pslverr
);
    import fp_pkg::*;

    // register block to converter
    logic        start;
    logic [31:0] operand;
    round_mode_t rm;
    // converter back to register block
    logic        busy;
    logic        valid;
    logic [31:0] result;
    fp_flags_t   flags;

    cvt_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .operand (operand),
        .rm      (rm),
        .busy    (busy),
        .valid   (valid),
        .result  (result),
        .flags   (flags)
    );

    uint_to_float u_conv (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .operand (operand),
        .rm      (rm),
        .busy    (busy),
        .valid   (valid),
        .result  (result),
        .flags   (flags)
    );

endmodule

// ==== verif/cvt_props.sv ====
module cvt_props (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic start,
    input logic busy,
    input logic valid,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // read by the testbench at the end

    pready_high: assert property (@(posedge clk) pready)
        else begin $error("pready went low"); fail_count++; end

    valid_pulse: assert property (@(posedge clk) disable iff (!rst) valid |=> !valid)
        else begin $error("valid high two cycles in a row"); fail_count++; end

    busy_ends_on_valid: assert property (@(posedge clk) disable iff (!rst)
        valid == $fell(busy))
        else begin $error("busy fall and valid out of step"); fail_count++; end

    start_when_idle: assert property (@(posedge clk) disable iff (!rst) start |-> !busy)
        else begin $error("start raised while converter busy"); fail_count++; end

    done_clears: assert property (@(posedge clk) disable iff (!rst) start |=> !done)
        else begin $error("done still set after start"); fail_count++; end

endmodule

bind cvt_top cvt_props u_props (
    .clk     (clk),
    .rst     (rst),
    .pready  (pready),
    .start   (start),
    .busy    (busy),
    .valid   (valid),
    .done    (u_regs.done_q)
);

// ==== verif/cvt_tb.sv ====
`include "cvt_defines.svh"

module cvt_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fp_pkg::*;

    localparam int     num_ops   = 250;
    localparam int     max_polls = 20;  // 60 cycles, longest conversion is 37
    localparam longint wd_ns     = longint'(num_ops) * 40 * 100 + 200000;

    localparam logic [31:0] exact_ops [4] = '{32'h0000_0000, 32'h0000_0001,
                                             32'h8000_0000, 32'h0001_0000};
    // ties, odd tie with carry, round bit only
    localparam logic [31:0] inexact_ops [5] = '{32'hFFFF_FFFF, 32'h0100_0001,
                                               32'h0100_0003, 32'h7FFF_FFC0, 32'h8000_0040};

    logic               clk = 1'b0;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`CVT_AW-1:0] paddr;
    logic [`CVT_DW-1:0] pwdata;
    logic [`CVT_DW-1:0] prdata;
    logic               pready;
    logic               pslverr;
    int                 errors = 0;

    cvt_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    // expected {nx, float} for an unsigned operand
    function automatic logic [32:0] model_convert(input logic [31:0] op, input logic [2:0] mode);
        int          msb;
        logic [31:0] norm;
        logic [24:0] sum;
        logic [7:0]  expo;
        logic        g;
        logic        r;
        logic        s;
        logic        nx;
        logic        up;
        if (op == 32'd0) begin
            return 33'd0;
        end
        msb = 31;
        while (!op[msb])
            msb--;
        norm = op << (31 - msb);  // leading one to bit 31
        g    = norm[7];
        r    = norm[6];
        s    = |norm[5:0];
        nx   = g | r | s;
        case (mode)
            rtz, rdn: up = 1'b0;
            rup:      up = nx;
            rmm:      up = g;
            default:  up = g & (r | s | norm[8]);
        endcase
        sum  = {1'b0, norm[31:8]} + {24'd0, up};
        expo = 8'(msb + 127);
        if (sum[24]) begin
            expo = expo + 8'd1;
            sum  = sum >> 1;
        end
        return {nx, 1'b0, expo, sum[22:0]};
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("FAILURE: %s", msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expv, actv);
        end
    endtask

    // one apb transfer, results sampled mid access phase
    task automatic apb_xfer(input logic write, input logic [`CVT_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] st);
        logic err;
        int   polls;
        polls = 0;
        do begin
            apb_xfer(1'b0, `CVT_REG_STATUS, 32'd0, st, err);
            polls++;
        end while (!st[1] && polls < max_polls);
        assert (st[1]) else report_failure("conversion never set done in STATUS");
    endtask

    task automatic run_case(input logic [31:0] op, input logic [2:0] mode);
        logic [32:0] expv;
        logic [31:0] rd;
        logic [31:0] st;
        logic        err;
        expv = model_convert(op, mode);
        apb_xfer(1'b1, `CVT_REG_CTRL, {29'd0, mode}, rd, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        apb_xfer(1'b1, `CVT_REG_OPERAND, op, rd, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        wait_done(st);
        check_value("status", {25'd0, 4'd0, expv[32], 2'b10}, st);  // nx in bit 2
        apb_xfer(1'b0, `CVT_REG_RESULT, 32'd0, rd, err);
        check_value("result", expv[31:0], rd);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] keep;
        logic [32:0] expv;
        logic        err;
        void'($urandom(18));
        rst     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        apb_xfer(1'b0, `CVT_REG_STATUS, 32'd0, rd, err);
        check_value("status", 32'd0, rd);
        apb_xfer(1'b0, `CVT_REG_CTRL, 32'd0, rd, err);
        check_value("ctrl", 32'd0, rd);
        apb_xfer(1'b0, 4'h2, 32'd0, rd, err);  // unmapped
        check_value("prdata", 32'd0, rd);

        foreach (exact_ops[i])
            for (int m = 0; m < 5; m++)
                run_case(exact_ops[i], 3'(m));
        foreach (inexact_ops[i])
            for (int m = 0; m < 5; m++)
                run_case(inexact_ops[i], 3'(m));
        repeat (200)
            run_case($urandom() >> $urandom_range(0, 31), 3'($urandom_range(0, 7)));

        // second operand while the first is still shifting
        expv = model_convert(32'h3, rne);
        apb_xfer(1'b1, `CVT_REG_CTRL, 32'd0, rd, err);
        apb_xfer(1'b1, `CVT_REG_OPERAND, 32'h3, rd, err);
        apb_xfer(1'b1, `CVT_REG_OPERAND, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        wait_done(rd);
        apb_xfer(1'b0, `CVT_REG_RESULT, 32'd0, rd, err);
        check_value("result", expv[31:0], rd);
        apb_xfer(1'b0, `CVT_REG_OPERAND, 32'd0, rd, err);
        check_value("operand", 32'h3, rd);

        // read-only registers refuse writes
        apb_xfer(1'b0, `CVT_REG_RESULT, 32'd0, keep, err);
        apb_xfer(1'b1, `CVT_REG_RESULT, 32'hDEAD_BEEF, rd, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, `CVT_REG_RESULT, 32'd0, rd, err);
        check_value("result", keep, rd);
        apb_xfer(1'b0, `CVT_REG_STATUS, 32'd0, keep, err);
        apb_xfer(1'b1, `CVT_REG_STATUS, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, `CVT_REG_STATUS, 32'd0, rd, err);
        check_value("status", keep, rd);

        repeat (5) @(posedge clk);
        $display("errors: %0d value checks, %0d bus assertions",
                 errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(wd_ns);
        $display("watchdog expired before all conversions finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
source/fp_pkg.sv
source/csr_pkg.sv
source/fp_round.sv
source/uint_to_float.sv
source/cvt_apb_regs.sv
source/cvt_top.sv
verif/cvt_props.sv
verif/cvt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cvt_tb -f files.f -o cvt_sim
./obj_dir/cvt_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: test failed"
    exit 1
fi
echo "run_sim: test passed"
